/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the tile testbench with Verilator.
# Pass or fail is decided by searching the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_tile_proc -o tb_tile_proc -f sim.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

./obj_dir/tb_tile_proc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
   exit 0
fi
exit 1

/* sim.f */
src/tile_cfg_pkg.sv
src/tile_pkt_pkg.sv
src/net_rx_decode.sv
src/remote_store_tx.sv
src/banked_mem_xbar.sv
src/tile_proc_top.sv
testbench/tb_tile_proc.sv

/* src/banked_mem_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_xbar #(
   parameter int bank_size_p = 256,
   parameter int num_banks_p = 2
) (
   input  logic                clk_i,
   input  logic                reset_i,

   input  logic                inst_v_i,
   input  tile_cfg_pkg::addr_t inst_addr_i,
   output logic                inst_yumi_o,
   output logic                inst_rv_o,
   output tile_cfg_pkg::data_t inst_rdata_o,

   input  logic                dl_v_i,
   input  logic                dl_w_i,
   input  tile_cfg_pkg::addr_t dl_addr_i,
   input  tile_cfg_pkg::data_t dl_wdata_i,
   input  tile_cfg_pkg::mask_t dl_mask_i,
   input  logic                dl_reserve_i,
   output logic                dl_yumi_o,
   output logic                dl_rv_o,
   output tile_cfg_pkg::data_t dl_rdata_o,

   input  logic                ns_v_i,
   input  tile_cfg_pkg::addr_t ns_addr_i,
   input  tile_cfg_pkg::data_t ns_data_i,
   input  tile_cfg_pkg::mask_t ns_mask_i,
   output logic                ns_yumi_o,

   output logic                reservation_o
);

   import tile_cfg_pkg::*;

   localparam int word_w_lp = $bits(addr_t) - 2;
   localparam int sel_lp    = $clog2(num_banks_p);
   localparam int bank_w_lp = (sel_lp > 0) ? sel_lp : 1;
   localparam int row_w_lp  = $clog2(bank_size_p);

   logic [word_w_lp-1:0] inst_word, dl_word, ns_word;
   logic [bank_w_lp-1:0] inst_bank, dl_bank, ns_bank;
   logic [bank_w_lp-1:0] inst_bank_r, dl_bank_r;
   logic [row_w_lp-1:0]  inst_row, dl_row, ns_row;
   logic [num_banks_p-1:0] inst_win, dl_win, ns_win;
   data_t bank_rdata [num_banks_p];
   logic reservation_r;
   logic [word_w_lp-1:0] resv_word_r;

   assign inst_word = inst_addr_i[2 +: word_w_lp];
   assign dl_word   = dl_addr_i[2 +: word_w_lp];
   assign ns_word   = ns_addr_i[2 +: word_w_lp];

   // low word bits interleave the banks, the rest is the row
   assign inst_bank = (num_banks_p > 1) ? inst_word[bank_w_lp-1:0] : '0;
   assign dl_bank   = (num_banks_p > 1) ? dl_word[bank_w_lp-1:0] : '0;
   assign ns_bank   = (num_banks_p > 1) ? ns_word[bank_w_lp-1:0] : '0;
   assign inst_row  = inst_word[sel_lp +: row_w_lp];
   assign dl_row    = dl_word[sel_lp +: row_w_lp];
   assign ns_row    = ns_word[sel_lp +: row_w_lp];

   for (genvar b = 0; b < num_banks_p; b++)
   begin : g_bank
      data_t mem [bank_size_p];
      data_t rdata_r;
      logic inst_hit, dl_hit, ns_hit;
      logic [row_w_lp-1:0] row;
      logic we;
      data_t wdata;
      mask_t wmask;

      assign inst_hit = inst_v_i & (inst_bank == bank_w_lp'(b));
      assign dl_hit   = dl_v_i & (dl_bank == bank_w_lp'(b));
      assign ns_hit   = ns_v_i & (ns_bank == bank_w_lp'(b));

      // core data first, then the network store, then instruction fetch
      assign dl_win[b]   = dl_hit;
      assign ns_win[b]   = ns_hit & ~dl_hit;
      assign inst_win[b] = inst_hit & ~dl_hit & ~ns_hit;

      always_comb
      begin
         row   = inst_row;
         we    = 1'b0;
         wdata = dl_wdata_i;
         wmask = dl_mask_i;
         if (dl_hit)
         begin
            row = dl_row;
            we  = dl_w_i;
         end
         else if (ns_hit)
         begin
            row   = ns_row;
            we    = 1'b1;
            wdata = ns_data_i;
            wmask = ns_mask_i;
         end
      end

      always_ff @(posedge clk_i)
      begin
         if (we)
         begin
            for (int i = 0; i < $bits(mask_t); i++)
            begin
               if (wmask[i])
               begin
                  mem[row][8*i +: 8] <= wdata[8*i +: 8];
               end
            end
         end
         else
         begin
            rdata_r <= mem[row];
         end
      end

      assign bank_rdata[b] = rdata_r;
   end

   assign inst_yumi_o = |inst_win;
   assign dl_yumi_o   = |dl_win;
   assign ns_yumi_o   = |ns_win;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         inst_rv_o <= 1'b0;
         dl_rv_o   <= 1'b0;
      end
      else
      begin
         inst_rv_o <= inst_yumi_o;
         dl_rv_o   <= dl_yumi_o & ~dl_w_i;
      end
   end

   // remember which bank answers each port next cycle
   always_ff @(posedge clk_i)
   begin
      if (inst_yumi_o)
      begin
         inst_bank_r <= inst_bank;
      end
      if (dl_yumi_o)
      begin
         dl_bank_r <= dl_bank;
      end
   end

   assign inst_rdata_o = bank_rdata[inst_bank_r];
   assign dl_rdata_o   = bank_rdata[dl_bank_r];

   // a committed network store to the reserved word breaks the reservation
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         reservation_r <= 1'b0;
      end
      else if (dl_yumi_o & dl_reserve_i & ~dl_w_i)
      begin
         reservation_r <= 1'b1;
      end
      else if (ns_yumi_o && ns_word == resv_word_r)
      begin
         reservation_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (dl_yumi_o & dl_reserve_i & ~dl_w_i)
      begin
         resv_word_r <= dl_word;
      end
   end

   assign reservation_o = reservation_r;

endmodule

`default_nettype wire

/* src/net_rx_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module net_rx_decode #(
   parameter int rx_fifo_els_p = 4
) (
   input  logic                  clk_i,
   input  logic                  reset_i,

   input  logic                  in_v_i,
   input  tile_pkt_pkg::packet_t in_data_i,
   output logic                  in_ready_o,

   output logic                  store_v_o,
   output tile_cfg_pkg::addr_t   store_addr_o,
   output tile_cfg_pkg::data_t   store_data_o,
   output tile_cfg_pkg::mask_t   store_mask_o,
   input  logic                  store_yumi_i,

   output logic                  freeze_o,
   output logic                  credit_o,
   output logic                  unknown_o
);

   import tile_pkt_pkg::*;

   localparam int ptr_w_lp   = (rx_fifo_els_p > 1) ? $clog2(rx_fifo_els_p) : 1;
   localparam int count_w_lp = $clog2(rx_fifo_els_p + 1);

   packet_t fifo_mem [rx_fifo_els_p];
   logic [ptr_w_lp-1:0] rd_ptr_r, wr_ptr_r;
   logic [count_w_lp-1:0] count_r;
   logic push, pop;
   logic head_v;
   packet_t head_pkt;
   pkt_op_e head_op;
   logic freeze_r;

   function automatic logic [ptr_w_lp-1:0] ptr_next(input logic [ptr_w_lp-1:0] p);
      return (p == ptr_w_lp'(rx_fifo_els_p - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready_o = (count_r != count_w_lp'(rx_fifo_els_p));
   assign push       = in_v_i & in_ready_o;

   assign head_v   = (count_r != '0);
   assign head_pkt = fifo_mem[rd_ptr_r];
   assign head_op  = pkt_op_e'(head_pkt[pkt_op_lsb +: pkt_op_w]);

   // a store waits for the memory, every other op leaves at once
   assign store_v_o = head_v & (head_op == op_store);
   assign pop       = head_v & ((head_op != op_store) | store_yumi_i);

   assign store_addr_o = head_pkt[pkt_addr_lsb +: pkt_addr_w];
   assign store_data_o = head_pkt[pkt_data_lsb +: pkt_data_w];
   assign store_mask_o = head_pkt[pkt_mask_lsb +: pkt_mask_w];

   // one credit back to the sender per store written
   assign credit_o  = store_v_o & store_yumi_i;
   assign unknown_o = head_v & (head_op == op_unknown);

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         fifo_mem[wr_ptr_r] <= in_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= ptr_next(wr_ptr_r);
         end
         if (pop)
         begin
            rd_ptr_r <= ptr_next(rd_ptr_r);
         end
         if (push & ~pop)
         begin
            count_r <= count_r + 1'b1;
         end
         else if (pop & ~push)
         begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   // the core starts frozen until the host unfreezes it
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         freeze_r <= 1'b1;
      end
      else if (head_v && head_op == op_freeze)
      begin
         freeze_r <= 1'b1;
      end
      else if (head_v && head_op == op_unfreeze)
      begin
         freeze_r <= 1'b0;
      end
   end

   assign freeze_o = freeze_r;

endmodule

`default_nettype wire

/* src/remote_store_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module remote_store_tx #(
   parameter int max_credits_p = 8
) (
   input  logic                  clk_i,
   input  logic                  reset_i,

   input  logic                  req_v_i,
   input  tile_cfg_pkg::addr_t   addr_i,
   input  tile_cfg_pkg::data_t   data_i,
   input  tile_cfg_pkg::mask_t   mask_i,
   output logic                  launch_o,

   output logic                  net_v_o,
   output tile_pkt_pkg::packet_t net_data_o,
   input  logic                  net_ready_i,
   input  logic                  credit_i,

   output logic                  outstanding_o
);

   import tile_cfg_pkg::*;
   import tile_pkt_pkg::*;

   localparam int credit_w_lp = $clog2(max_credits_p + 1);

   logic [credit_w_lp-1:0] credits_r;
   x_cord_t dest_x;
   y_cord_t dest_y;

   assign dest_x = addr_i[dest_x_lsb +: $bits(x_cord_t)];
   assign dest_y = addr_i[dest_y_lsb +: $bits(y_cord_t)];

   always_comb
   begin
      net_data_o = '0;
      net_data_o[pkt_op_lsb   +: pkt_op_w]   = op_store;
      net_data_o[pkt_mask_lsb +: pkt_mask_w] = mask_i;
      net_data_o[pkt_addr_lsb +: pkt_addr_w] = addr_i;
      net_data_o[pkt_data_lsb +: pkt_data_w] = data_i;
      net_data_o[pkt_y_lsb    +: pkt_y_w]    = dest_y;
      net_data_o[pkt_x_lsb    +: pkt_x_w]    = dest_x;
   end

   // no request goes out without a credit in hand
   assign net_v_o  = req_v_i & (credits_r != '0);
   assign launch_o = net_v_o & net_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         credits_r <= credit_w_lp'(max_credits_p);
      end
      else if (launch_o & ~credit_i)
      begin
         credits_r <= credits_r - 1'b1;
      end
      else if (credit_i & ~launch_o)
      begin
         // saturate if the mesh returns more than was taken
         if (credits_r != credit_w_lp'(max_credits_p))
         begin
            credits_r <= credits_r + 1'b1;
         end
      end
   end

   // used by the core as a fence condition
   assign outstanding_o = (credits_r != credit_w_lp'(max_credits_p));

endmodule

`default_nettype wire

/* src/tile_cfg_pkg.sv */
`default_nettype none

package tile_cfg_pkg;

   // byte address as seen by the core and carried in packets
   typedef logic [31:0] addr_t;

   // one memory word
   typedef logic [31:0] data_t;

   // byte enables, one per byte of data_t
   typedef logic [3:0] mask_t;

   // mesh coordinates of a tile
   typedef logic [3:0] x_cord_t;
   typedef logic [3:0] y_cord_t;

   // set in an address that leaves the tile
   localparam int remote_bit = 31;

   // destination coordinates inside a remote address
   localparam int dest_x_lsb = 24;
   localparam int dest_y_lsb = 20;

endpackage

`default_nettype wire

/* src/tile_pkt_pkg.sv */
`default_nettype none

package tile_pkt_pkg;

   typedef enum logic [1:0] {
      op_store    = 2'd0,
      op_freeze   = 2'd1,
      op_unfreeze = 2'd2,
      op_unknown  = 2'd3
   } pkt_op_e;

   // field widths follow the tile vector types
   localparam int pkt_x_w    = $bits(tile_cfg_pkg::x_cord_t);
   localparam int pkt_y_w    = $bits(tile_cfg_pkg::y_cord_t);
   localparam int pkt_data_w = $bits(tile_cfg_pkg::data_t);
   localparam int pkt_addr_w = $bits(tile_cfg_pkg::addr_t);
   localparam int pkt_mask_w = $bits(tile_cfg_pkg::mask_t);
   localparam int pkt_op_w   = $bits(pkt_op_e);

   // fields from the bottom up are x, y, data, addr, mask and op
   localparam int pkt_x_lsb    = 0;
   localparam int pkt_y_lsb    = pkt_x_lsb + pkt_x_w;
   localparam int pkt_data_lsb = pkt_y_lsb + pkt_y_w;
   localparam int pkt_addr_lsb = pkt_data_lsb + pkt_data_w;
   localparam int pkt_mask_lsb = pkt_addr_lsb + pkt_addr_w;
   localparam int pkt_op_lsb   = pkt_mask_lsb + pkt_mask_w;

   localparam int packet_width = pkt_op_lsb + pkt_op_w;

   typedef logic [packet_width-1:0] packet_t;

endpackage

`default_nettype wire

/* src/tile_proc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_proc_top #(
   parameter int bank_size_p   = 256,
   parameter int num_banks_p   = 2,
   parameter int rx_fifo_els_p = 4,
   parameter int max_credits_p = 8
) (
   input  logic                  clk_i,
   input  logic                  reset_i,

   // core instruction port
   input  logic                  inst_v_i,
   input  tile_cfg_pkg::addr_t   inst_addr_i,
   output logic                  inst_yumi_o,
   output logic                  inst_rv_o,
   output tile_cfg_pkg::data_t   inst_rdata_o,

   // core data port
   input  logic                  data_v_i,
   input  logic                  data_w_i,
   input  tile_cfg_pkg::addr_t   data_addr_i,
   input  tile_cfg_pkg::data_t   data_wdata_i,
   input  tile_cfg_pkg::mask_t   data_mask_i,
   input  logic                  data_reserve_i,
   output logic                  data_yumi_o,
   output logic                  data_rv_o,
   output tile_cfg_pkg::data_t   data_rdata_o,
   output logic                  reservation_o,
   output logic                  outstanding_o,
   output logic                  freeze_o,

   // mesh side
   input  logic                  net_in_v_i,
   input  tile_pkt_pkg::packet_t net_in_data_i,
   output logic                  net_in_ready_o,
   output logic                  net_out_v_o,
   output tile_pkt_pkg::packet_t net_out_data_o,
   input  logic                  net_out_ready_i,
   input  logic                  credit_i,
   output logic                  credit_o,
   output logic                  unknown_o
);

   import tile_cfg_pkg::*;

   logic  is_remote;
   logic  dl_v, dl_yumi, tx_req_v, tx_launch;
   logic  ns_v, ns_yumi;
   addr_t ns_addr;
   data_t ns_data;
   mask_t ns_mask;

   // the remote bit picks either local memory or the mesh
   assign is_remote   = data_addr_i[remote_bit];
   assign dl_v        = data_v_i & ~is_remote;
   assign tx_req_v    = data_v_i & is_remote;
   assign data_yumi_o = dl_yumi | tx_launch;

   net_rx_decode #(
      .rx_fifo_els_p (rx_fifo_els_p)
   ) rx (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_v_i       (net_in_v_i),
      .in_data_i    (net_in_data_i),
      .in_ready_o   (net_in_ready_o),
      .store_v_o    (ns_v),
      .store_addr_o (ns_addr),
      .store_data_o (ns_data),
      .store_mask_o (ns_mask),
      .store_yumi_i (ns_yumi),
      .freeze_o     (freeze_o),
      .credit_o     (credit_o),
      .unknown_o    (unknown_o)
   );

   remote_store_tx #(
      .max_credits_p (max_credits_p)
   ) tx (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .req_v_i       (tx_req_v),
      .addr_i        (data_addr_i),
      .data_i        (data_wdata_i),
      .mask_i        (data_mask_i),
      .launch_o      (tx_launch),
      .net_v_o       (net_out_v_o),
      .net_data_o    (net_out_data_o),
      .net_ready_i   (net_out_ready_i),
      .credit_i      (credit_i),
      .outstanding_o (outstanding_o)
   );

   banked_mem_xbar #(
      .bank_size_p (bank_size_p),
      .num_banks_p (num_banks_p)
   ) xbar (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .inst_v_i      (inst_v_i),
      .inst_addr_i   (inst_addr_i),
      .inst_yumi_o   (inst_yumi_o),
      .inst_rv_o     (inst_rv_o),
      .inst_rdata_o  (inst_rdata_o),
      .dl_v_i        (dl_v),
      .dl_w_i        (data_w_i),
      .dl_addr_i     (data_addr_i),
      .dl_wdata_i    (data_wdata_i),
      .dl_mask_i     (data_mask_i),
      .dl_reserve_i  (data_reserve_i),
      .dl_yumi_o     (dl_yumi),
      .dl_rv_o       (data_rv_o),
      .dl_rdata_o    (data_rdata_o),
      .ns_v_i        (ns_v),
      .ns_addr_i     (ns_addr),
      .ns_data_i     (ns_data),
      .ns_mask_i     (ns_mask),
      .ns_yumi_o     (ns_yumi),
      .reservation_o (reservation_o)
   );

endmodule

`default_nettype wire

/* testbench/tb_tile_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tile_proc;

   import tile_cfg_pkg::*;
   import tile_pkt_pkg::*;

   localparam int bank_size_lp   = 256;
   localparam int num_banks_lp   = 2;
   localparam int rx_fifo_els_lp = 4;
   localparam int max_credits_lp = 8;
   localparam int wait_limit     = 200;

   logic    clk_i;
   logic    reset_i;
   logic    inst_v_i;
   addr_t   inst_addr_i;
   logic    inst_yumi_o;
   logic    inst_rv_o;
   data_t   inst_rdata_o;
   logic    data_v_i;
   logic    data_w_i;
   addr_t   data_addr_i;
   data_t   data_wdata_i;
   mask_t   data_mask_i;
   logic    data_reserve_i;
   logic    data_yumi_o;
   logic    data_rv_o;
   data_t   data_rdata_o;
   logic    reservation_o;
   logic    outstanding_o;
   logic    freeze_o;
   logic    net_in_v_i;
   packet_t net_in_data_i;
   logic    net_in_ready_o;
   logic    net_out_v_o;
   packet_t net_out_data_o;
   logic    net_out_ready_i;
   logic    credit_i;
   logic    credit_o;
   logic    unknown_o;

   // reference state kept by the compare process
   data_t   ref_mem [64];
   packet_t rx_q [$];
   packet_t bp_pkts [rx_fifo_els_lp + 2];
   logic    inst_pend;
   logic    data_pend;
   data_t   inst_exp;
   data_t   data_exp;
   int      credit_count;
   int      unknown_count;
   int      launch_count;
   int      in_store_count;
   int      mismatch_count;
   int      failure_count;
   int      seed;

   tile_proc_top #(
      .bank_size_p   (bank_size_lp),
      .num_banks_p   (num_banks_lp),
      .rx_fifo_els_p (rx_fifo_els_lp),
      .max_credits_p (max_credits_lp)
   ) dut (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .inst_v_i        (inst_v_i),
      .inst_addr_i     (inst_addr_i),
      .inst_yumi_o     (inst_yumi_o),
      .inst_rv_o       (inst_rv_o),
      .inst_rdata_o    (inst_rdata_o),
      .data_v_i        (data_v_i),
      .data_w_i        (data_w_i),
      .data_addr_i     (data_addr_i),
      .data_wdata_i    (data_wdata_i),
      .data_mask_i     (data_mask_i),
      .data_reserve_i  (data_reserve_i),
      .data_yumi_o     (data_yumi_o),
      .data_rv_o       (data_rv_o),
      .data_rdata_o    (data_rdata_o),
      .reservation_o   (reservation_o),
      .outstanding_o   (outstanding_o),
      .freeze_o        (freeze_o),
      .net_in_v_i      (net_in_v_i),
      .net_in_data_i   (net_in_data_i),
      .net_in_ready_o  (net_in_ready_o),
      .net_out_v_o     (net_out_v_o),
      .net_out_data_o  (net_out_data_o),
      .net_out_ready_i (net_out_ready_i),
      .credit_i        (credit_i),
      .credit_o        (credit_o),
      .unknown_o       (unknown_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #50 clk_i = ~clk_i;
      end
   end

   task automatic note_mismatch(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      mismatch_count++;
   endtask

   task automatic note_failure(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      failure_count++;
   endtask

   function automatic addr_t word_addr(input int w);
      return addr_t'(w * 4);
   endfunction

   function automatic data_t expected_read(input addr_t addr);
      return ref_mem[addr[7:2]];
   endfunction

   // op, mask, addr, data, then y and x taken from the remote address
   function automatic packet_t expected_packet(input addr_t addr, input data_t data,
                                               input mask_t mask);
      return {op_store, mask, addr, data, addr[23:20], addr[27:24]};
   endfunction

   function automatic packet_t make_packet(input pkt_op_e op, input addr_t addr,
                                           input data_t data, input mask_t mask);
      return {op, mask, addr, data, 8'h00};
   endfunction

   task automatic apply_write(input addr_t addr, input data_t data, input mask_t mask);
      for (int i = 0; i < 4; i++)
      begin
         if (mask[i])
         begin
            ref_mem[addr[7:2]][8*i +: 8] = data[8*i +: 8];
         end
      end
   endtask

   // a credit means the oldest queued store was written
   task automatic apply_net_store();
      packet_t p;
      logic found;
      found = 1'b0;
      p = '0;
      while (rx_q.size() > 0 && !found)
      begin
         p = rx_q.pop_front();
         found = (p[77:76] == op_store);
      end
      if (!found)
      begin
         note_failure("credit_o pulsed with no store pending");
      end
      else
      begin
         apply_write(p[71:40], p[39:8], p[75:72]);
      end
   endtask

   // compare process samples mid-cycle where everything is settled
   always @(negedge clk_i)
   begin
      if (reset_i)
      begin
         inst_pend = 1'b0;
         data_pend = 1'b0;
      end
      else
      begin
         if (inst_rv_o !== inst_pend)
         begin
            note_failure("inst_rv_o did not follow its yumi by one cycle");
         end
         else if (inst_pend && inst_rdata_o !== inst_exp)
         begin
            note_mismatch($sformatf("inst read %h, expected %h", inst_rdata_o, inst_exp));
         end
         if (data_rv_o !== data_pend)
         begin
            note_failure("data_rv_o did not follow its yumi by one cycle");
         end
         else if (data_pend && data_rdata_o !== data_exp)
         begin
            note_mismatch($sformatf("data read %h, expected %h", data_rdata_o, data_exp));
         end
         inst_pend = inst_yumi_o;
         if (inst_yumi_o)
         begin
            inst_exp = expected_read(inst_addr_i);
         end
         data_pend = data_yumi_o && !data_addr_i[31] && !data_w_i;
         if (data_pend)
         begin
            data_exp = expected_read(data_addr_i);
         end
         if (data_yumi_o && !data_addr_i[31] && data_w_i)
         begin
            apply_write(data_addr_i, data_wdata_i, data_mask_i);
         end
         if (data_yumi_o && data_addr_i[31])
         begin
            launch_count++;
            if (!net_out_v_o)
            begin
               note_failure("remote store accepted without net_out_v_o");
            end
            if (net_out_data_o !== expected_packet(data_addr_i, data_wdata_i, data_mask_i))
            begin
               note_mismatch($sformatf("packet %h, expected %h", net_out_data_o,
                  expected_packet(data_addr_i, data_wdata_i, data_mask_i)));
            end
         end
         if (unknown_o)
         begin
            unknown_count++;
         end
         if (credit_o)
         begin
            credit_count++;
            apply_net_store();
         end
         if (net_in_v_i && net_in_ready_o)
         begin
            rx_q.push_back(net_in_data_i);
            if (net_in_data_i[77:76] == op_store)
            begin
               in_store_count++;
            end
         end
      end
   end

   task automatic data_access(input addr_t addr, input logic w, input data_t wdata,
                              input mask_t mask, input logic reserve);
      int t;
      t = 0;
      data_v_i       = 1'b1;
      data_w_i       = w;
      data_addr_i    = addr;
      data_wdata_i   = wdata;
      data_mask_i    = mask;
      data_reserve_i = reserve;
      @(negedge clk_i);
      while (!data_yumi_o && t < wait_limit)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!data_yumi_o)
      begin
         note_failure("timeout waiting for data_yumi_o");
      end
      @(posedge clk_i);
      #1;
      data_v_i       = 1'b0;
      data_reserve_i = 1'b0;
   endtask

   task automatic inst_fetch(input addr_t addr);
      int t;
      t = 0;
      inst_v_i    = 1'b1;
      inst_addr_i = addr;
      @(negedge clk_i);
      while (!inst_yumi_o && t < wait_limit)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!inst_yumi_o)
      begin
         note_failure("timeout waiting for inst_yumi_o");
      end
      @(posedge clk_i);
      #1;
      inst_v_i = 1'b0;
   endtask

   task automatic send_packet(input packet_t p);
      int t;
      t = 0;
      net_in_v_i    = 1'b1;
      net_in_data_i = p;
      @(negedge clk_i);
      while (!net_in_ready_o && t < wait_limit)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!net_in_ready_o)
      begin
         note_failure("timeout waiting for net_in_ready_o");
      end
      @(posedge clk_i);
      #1;
      net_in_v_i = 1'b0;
   endtask

   task automatic wait_freeze(input logic val);
      int t;
      t = 0;
      @(negedge clk_i);
      while (freeze_o !== val && t < wait_limit)
      begin
         @(negedge clk_i);
         t++;
      end
      if (freeze_o !== val)
      begin
         note_failure("timeout waiting for freeze_o to change");
      end
      @(posedge clk_i);
      #1;
   endtask

   // counters move at the falling edge and are polled at the rising one
   task automatic wait_credits(input int target);
      int t;
      t = 0;
      @(posedge clk_i);
      while (credit_count < target && t < wait_limit)
      begin
         @(posedge clk_i);
         t++;
      end
      if (credit_count < target)
      begin
         note_failure("timeout waiting for credit_o pulses");
      end
      #1;
   endtask

   task automatic wait_unknown(input int target);
      int t;
      t = 0;
      @(posedge clk_i);
      while (unknown_count < target && t < wait_limit)
      begin
         @(posedge clk_i);
         t++;
      end
      if (unknown_count < target)
      begin
         note_failure("timeout waiting for unknown_o");
      end
      #1;
   endtask

   initial
   begin
      int base;
      int taken;
      int w;
      addr_t addr;
      seed           = 57;
      mismatch_count = 0;
      failure_count  = 0;
      credit_count   = 0;
      unknown_count  = 0;
      launch_count   = 0;
      in_store_count = 0;
      reset_i        = 1'b1;
      inst_v_i       = 1'b0;
      inst_addr_i    = '0;
      data_v_i       = 1'b0;
      data_w_i       = 1'b0;
      data_addr_i    = '0;
      data_wdata_i   = '0;
      data_mask_i    = '0;
      data_reserve_i = 1'b0;
      net_in_v_i     = 1'b0;
      net_in_data_i  = '0;
      net_out_ready_i = 1'b1;
      credit_i       = 1'b0;
      repeat (10) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      @(negedge clk_i);
      if (freeze_o !== 1'b1 || reservation_o !== 1'b0 || outstanding_o !== 1'b0)
      begin
         note_failure("freeze, reservation or outstanding wrong after reset");
      end
      if (net_out_v_o !== 1'b0 || credit_o !== 1'b0 || unknown_o !== 1'b0)
      begin
         note_failure("network outputs not idle after reset");
      end
      @(posedge clk_i);
      #1;

      send_packet(make_packet(op_unfreeze, '0, '0, '0));
      wait_freeze(1'b0);
      send_packet(make_packet(op_freeze, '0, '0, '0));
      wait_freeze(1'b1);

      // fill the words under test so no read sees an unwritten word
      for (int i = 0; i < 16; i++)
      begin
         data_access(word_addr(i), 1'b1, data_t'($random(seed)), 4'hf, 1'b0);
      end

      base = credit_count;
      send_packet(make_packet(op_unknown, word_addr(3), 32'hdead_beef, 4'hf));
      wait_unknown(1);
      @(negedge clk_i);
      if (freeze_o !== 1'b1)
      begin
         note_failure("unknown packet changed freeze_o");
      end
      @(posedge clk_i);
      if (credit_count != base)
      begin
         note_failure("unknown packet returned a credit");
      end
      #1;
      data_access(word_addr(3), 1'b0, '0, '0, 1'b0);

      // masked local traffic with fetches running alongside
      fork
         begin
            for (int i = 0; i < 40; i++)
            begin
               data_access(word_addr($random(seed) & 15), 1'($random(seed)),
                           data_t'($random(seed)), mask_t'($random(seed)), 1'b0);
            end
         end
         begin
            for (int i = 0; i < 30; i++)
            begin
               inst_fetch(word_addr($random(seed) & 15));
            end
         end
      join

      base = credit_count;
      for (int i = 0; i < 6; i++)
      begin
         w = $random(seed) & 15;
         send_packet(make_packet(op_store, word_addr(w), data_t'($random(seed)),
                                 mask_t'($random(seed))));
      end
      wait_credits(base + 6);
      repeat (4) @(posedge clk_i);
      #1;
      if (credit_count != base + 6)
      begin
         note_failure("credit_o pulse count differs from stores sent");
      end
      for (int i = 0; i < 16; i++)
      begin
         data_access(word_addr(i), 1'b0, '0, '0, 1'b0);
      end

      // remote stores until the credits run out
      base = launch_count;
      for (int i = 0; i < max_credits_lp; i++)
      begin
         addr = 32'h8000_0000 | (addr_t'($random(seed)) & 32'h0fff_fffc);
         data_access(addr, 1'b1, data_t'($random(seed)), mask_t'($random(seed)), 1'b0);
      end
      if (launch_count != base + max_credits_lp)
      begin
         note_failure("remote store launch count wrong");
      end
      data_v_i    = 1'b1;
      data_w_i    = 1'b1;
      data_addr_i = 32'h8120_0040;
      repeat (8)
      begin
         @(negedge clk_i);
         if (data_yumi_o !== 1'b0 || net_out_v_o !== 1'b0 || outstanding_o !== 1'b1)
         begin
            note_failure("remote store went out with no credits left");
         end
      end
      @(posedge clk_i);
      #1;
      data_v_i = 1'b0;
      for (int i = 0; i < max_credits_lp; i++)
      begin
         credit_i = 1'b1;
         @(posedge clk_i);
         #1;
         credit_i = 1'b0;
         @(negedge clk_i);
         if (outstanding_o !== (i < max_credits_lp - 1))
         begin
            note_failure("outstanding_o wrong while credits return");
         end
         @(posedge clk_i);
         #1;
      end

      // the data port holds bank 0 so queued network stores cannot drain
      net_out_ready_i = 1'b0;
      base = credit_count;
      for (int i = 0; i < rx_fifo_els_lp + 2; i++)
      begin
         w = (i < 4) ? 2 * (i % 2) : 6;
         bp_pkts[i] = make_packet(op_store, word_addr(w), data_t'($random(seed)),
                                  mask_t'($random(seed)) | 4'h1);
      end
      data_v_i      = 1'b1;
      data_w_i      = 1'b0;
      data_addr_i   = word_addr(4);
      taken         = 0;
      net_in_v_i    = 1'b1;
      net_in_data_i = bp_pkts[0];
      for (int i = 0; i < 12; i++)
      begin
         @(negedge clk_i);
         if (net_in_v_i && net_in_ready_o)
         begin
            taken++;
         end
         @(posedge clk_i);
         #1;
         if (taken < rx_fifo_els_lp + 2)
         begin
            net_in_data_i = bp_pkts[taken];
         end
         else
         begin
            net_in_v_i = 1'b0;
         end
      end
      net_in_v_i = 1'b0;
      data_v_i   = 1'b0;
      if (taken > rx_fifo_els_lp + 1 || taken < rx_fifo_els_lp)
      begin
         note_failure($sformatf("input took %0d packets while stores were blocked", taken));
      end
      net_out_ready_i = 1'b1;
      wait_credits(base + taken);
      data_access(word_addr(0), 1'b0, '0, '0, 1'b0);
      data_access(word_addr(2), 1'b0, '0, '0, 1'b0);
      data_access(word_addr(6), 1'b0, '0, '0, 1'b0);

      // load-reserved, then stores beside and onto the reserved word
      data_access(word_addr(8), 1'b0, '0, '0, 1'b1);
      @(negedge clk_i);
      if (reservation_o !== 1'b1)
      begin
         note_failure("reserved load did not set reservation_o");
      end
      @(posedge clk_i);
      #1;
      base = credit_count;
      send_packet(make_packet(op_store, word_addr(10), data_t'($random(seed)), 4'hf));
      wait_credits(base + 1);
      @(negedge clk_i);
      if (reservation_o !== 1'b1)
      begin
         note_failure("store to another word cleared reservation_o");
      end
      @(posedge clk_i);
      #1;
      send_packet(make_packet(op_store, word_addr(8), data_t'($random(seed)), 4'hf));
      wait_credits(base + 2);
      @(negedge clk_i);
      if (reservation_o !== 1'b0)
      begin
         note_failure("store to the reserved word left reservation_o set");
      end
      @(posedge clk_i);
      #1;
      data_access(word_addr(8), 1'b0, '0, '0, 1'b0);

      repeat (3) @(posedge clk_i);
      if (credit_count != in_store_count)
      begin
         note_failure("credit_o pulses do not match accepted stores");
      end
      if (unknown_count != 1)
      begin
         note_failure("unknown_o pulsed for a packet that was not unknown");
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
